/* include/nn_cfg.svh */
// Layer configuration for the forward-forward inference engine
// Sizes, fixed-point format and the goodness threshold
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

// Pixels per input vector
`define NN_INPUT_SIZE   8

// Neuron lanes in the layer
`define NN_NUM_NEURONS  4

// Fraction bits of the Q16.16 format
`define NN_FRAC_BITS    16

// Goodness threshold, 3.0 in Q16.16
`define NN_THETA        32'sh0003_0000

`endif

/* verilog/nn_fixed_pkg.sv */
// Fixed-point types and helpers for Q16.16 arithmetic
`include "nn_cfg.svh"

package nn_fixed_pkg;

    // Signed Q16.16 value
    typedef logic signed [31:0] q16_t;

    // Full-width product and sum accumulator
    typedef logic signed [63:0] acc_t;

    // Rescale a sum, keep 32 bits, clamp negatives to zero
    function automatic q16_t relu_trunc(input acc_t a);
        acc_t shifted;
        q16_t t;
        shifted = a >>> `NN_FRAC_BITS;
        t = shifted[31:0];
        return (t < 0) ? '0 : t;
    endfunction

    // Square of a Q16.16 value, rescaled back to Q16.16 in a wide word
    function automatic acc_t sq_trunc(input q16_t a);
        acc_t wide;
        wide = acc_t'(a);
        return (wide * wide) >>> `NN_FRAC_BITS;
    endfunction

endpackage

/* verilog/nn_layer_pkg.sv */
// Layer structure types for the inference engine
// Index widths, the broadcast beat and the goodness result
`include "nn_cfg.svh"

package nn_layer_pkg;

    import nn_fixed_pkg::*;

    // Position of a pixel inside its vector
    typedef logic [$clog2(`NN_INPUT_SIZE)-1:0] pixel_idx_t;

    // Lane number
    typedef logic [$clog2(`NN_NUM_NEURONS)-1:0] neuron_idx_t;

    // One pixel as broadcast to every lane
    typedef struct packed {
        q16_t pixel;
        logic first;
        logic last;
    } beat_t;

    // Goodness of one vector and its classification
    typedef struct packed {
        q16_t goodness;
        logic is_positive;
    } score_t;

endpackage

/* verilog/stream_reg.sv */
// One-entry valid/ready register slice
// Payload type is set per instance
`timescale 1ns/1ns

module stream_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic s_valid,
    output logic s_ready,
    input  T     s_data,
    output logic m_valid,
    input  logic m_ready,
    output T     m_data
);

    logic full;
    T     data_q;

    // Accept when empty or when the held entry leaves this cycle
    assign s_ready = !full || m_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (s_valid && s_ready) begin
            full <= 1'b1;
        end else if (m_ready) begin
            full <= 1'b0;
        end
    end

    // Data only
    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            data_q <= s_data;
        end
    end

    assign m_valid = full;
    assign m_data  = data_q;

endmodule

/* verilog/pixel_feeder.sv */
// Pixel feeder for the neuron lanes
// Tags first and last beats, gates the last one on drain space, decodes weight writes
`timescale 1ns/1ns
`include "nn_cfg.svh"

module pixel_feeder
    import nn_fixed_pkg::*;
    import nn_layer_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       s_valid,
    output logic                       s_ready,
    input  q16_t                       s_pixel,
    input  logic                       cap_ready,
    output logic                       beat_valid,
    output beat_t                      beat,
    input  logic                       wt_we,
    input  neuron_idx_t                wt_neuron,
    output logic [`NN_NUM_NEURONS-1:0] wt_en
);

    pixel_idx_t pix_cnt;
    logic       is_first;
    logic       is_last;

    assign is_first = (pix_cnt == '0);
    assign is_last  = (pix_cnt == pixel_idx_t'(`NN_INPUT_SIZE - 1));

    // Last pixel waits until the goodness unit can take the activations
    assign s_ready    = !is_last || cap_ready;
    assign beat_valid = s_valid && s_ready;

    // Same-cycle broadcast of the accepted pixel
    always_comb begin
        beat.pixel = s_pixel;
        beat.first = is_first;
        beat.last  = is_last;
    end

    // Position in the current vector, wraps after the last pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt <= '0;
        end else if (beat_valid) begin
            if (is_last) begin
                pix_cnt <= '0;
            end else begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    // One-hot lane select for weight loading
    always_comb begin
        wt_en = '0;
        if (wt_we) begin
            wt_en[wt_neuron] = 1'b1;
        end
    end

endmodule

/* verilog/neuron_lane.sv */
// Single neuron lane
// Weight row, multiply-accumulate over one vector, ReLU at the last pixel
`timescale 1ns/1ns
`include "nn_cfg.svh"

module neuron_lane
    import nn_fixed_pkg::*;
    import nn_layer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wt_en,
    input  pixel_idx_t wt_index,
    input  q16_t       wt_data,
    input  logic       beat_valid,
    input  beat_t      beat,
    output logic       act_valid,
    output q16_t       act
);

    q16_t       weights [`NN_INPUT_SIZE];
    pixel_idx_t idx;
    pixel_idx_t waddr;
    acc_t       product;
    acc_t       acc;
    acc_t       acc_next;

    // Weight row, loaded between vectors
    always_ff @(posedge clk) begin
        if (wt_en) begin
            weights[wt_index] <= wt_data;
        end
    end

    // First beat forces index zero so the lane realigns on every vector
    assign waddr    = beat.first ? '0 : idx;
    assign product  = acc_t'(beat.pixel) * acc_t'(weights[waddr]);
    assign acc_next = (beat.first ? acc_t'(0) : acc) + product;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx       <= '0;
            act_valid <= 1'b0;
        end else begin
            act_valid <= beat_valid && beat.last;
            if (beat_valid) begin
                idx <= beat.last ? '0 : waddr + 1'b1;
            end
        end
    end

    // Running sum and the activation of the finished vector
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            acc <= acc_next;
            if (beat.last) begin
                act <= relu_trunc(acc_next);
            end
        end
    end

endmodule

/* verilog/goodness_unit.sv */
// Goodness unit
// Captures lane activations, sums their squares serially, compares with THETA
`timescale 1ns/1ns
`include "nn_cfg.svh"

module goodness_unit
    import nn_fixed_pkg::*;
    import nn_layer_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic act_valid,
    input  q16_t acts [`NN_NUM_NEURONS],
    output logic cap_ready,
    output logic m_valid,
    input  logic m_ready,
    output q16_t m_goodness,
    output logic m_positive
);

    q16_t        acts_q [`NN_NUM_NEURONS];
    acc_t        sum;
    acc_t        sum_next;
    neuron_idx_t idx;
    logic        busy;
    logic        last_term;
    logic        push_valid;
    logic        push_ready;
    score_t      push_score;
    score_t      out_score;

    // Snapshot of all lanes, frees them for the next vector
    always_ff @(posedge clk) begin
        if (act_valid) begin
            acts_q <= acts;
        end
    end

    assign sum_next   = sum + sq_trunc(acts_q[idx]);
    assign last_term  = (idx == neuron_idx_t'(`NN_NUM_NEURONS - 1));
    // Final term goes straight into the output slice
    assign push_valid = busy && last_term;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (!busy) begin
            if (act_valid) begin
                busy <= 1'b1;
                idx  <= '0;
            end
        end else if (!last_term) begin
            idx <= idx + 1'b1;
        end else if (push_ready) begin
            busy <= 1'b0;
        end
    end

    // Partial sum, cleared while idle
    always_ff @(posedge clk) begin
        if (!busy) begin
            sum <= '0;
        end else if (!last_term) begin
            sum <= sum_next;
        end
    end

    // Low 32 bits of the sum, signed compare against the threshold
    always_comb begin
        push_score.goodness    = sum_next[31:0];
        push_score.is_positive = (push_score.goodness > `NN_THETA);
    end

    // No new capture until the previous score has been taken downstream
    assign cap_ready = !busy && !m_valid;

    stream_reg #(
        .T (score_t)
    ) u_out_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (push_valid),
        .s_ready (push_ready),
        .s_data  (push_score),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_data  (out_score)
    );

    assign m_goodness = out_score.goodness;
    assign m_positive = out_score.is_positive;

endmodule

/* verilog/nn_layer_top.sv */
// Streaming fully connected layer with goodness output
// Input slice, feeder, neuron lanes and goodness unit
`timescale 1ns/1ns
`include "nn_cfg.svh"

module nn_layer_top
    import nn_fixed_pkg::*;
    import nn_layer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wt_we,
    input  neuron_idx_t wt_neuron,
    input  pixel_idx_t  wt_index,
    input  q16_t        wt_data,
    input  logic        in_valid,
    output logic        in_ready,
    input  q16_t        in_data,
    output logic        out_valid,
    input  logic        out_ready,
    output q16_t        out_goodness,
    output logic        out_positive
);

    // Input slice to feeder
    logic px_valid;
    logic px_ready;
    q16_t px_data;

    // Broadcast to lanes
    logic                       beat_valid;
    beat_t                      beat;
    logic [`NN_NUM_NEURONS-1:0] wt_en;

    // Lanes to goodness unit
    logic [`NN_NUM_NEURONS-1:0] act_valid;
    q16_t                       act [`NN_NUM_NEURONS];
    logic                       cap_ready;

    stream_reg #(
        .T (q16_t)
    ) u_in_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (in_valid),
        .s_ready (in_ready),
        .s_data  (in_data),
        .m_valid (px_valid),
        .m_ready (px_ready),
        .m_data  (px_data)
    );

    pixel_feeder u_feeder (
        .clk        (clk),
        .rst_n      (rst_n),
        .s_valid    (px_valid),
        .s_ready    (px_ready),
        .s_pixel    (px_data),
        .cap_ready  (cap_ready),
        .beat_valid (beat_valid),
        .beat       (beat),
        .wt_we      (wt_we),
        .wt_neuron  (wt_neuron),
        .wt_en      (wt_en)
    );

    // Identical lanes, weight index and data are shared
    for (genvar g = 0; g < `NN_NUM_NEURONS; g++) begin : g_lane
        neuron_lane u_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .wt_en      (wt_en[g]),
            .wt_index   (wt_index),
            .wt_data    (wt_data),
            .beat_valid (beat_valid),
            .beat       (beat),
            .act_valid  (act_valid[g]),
            .act        (act[g])
        );
    end

    // Lanes finish together, lane 0 strobes the capture
    goodness_unit u_goodness (
        .clk        (clk),
        .rst_n      (rst_n),
        .act_valid  (act_valid[0]),
        .acts       (act),
        .cap_ready  (cap_ready),
        .m_valid    (out_valid),
        .m_ready    (out_ready),
        .m_goodness (out_goodness),
        .m_positive (out_positive)
    );

endmodule

/* test/nn_layer_chk.sv */
// Handshake checker for the layer top level
// Bound into nn_layer_top, reports only through assertion failures
`timescale 1ns/1ns

module nn_layer_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        in_valid,
    input logic        in_ready,
    input logic [31:0] in_data,
    input logic        out_valid,
    input logic        out_ready,
    input logic [31:0] out_goodness,
    input logic        out_positive
);

    // Result holds with its data until taken
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_goodness)
            && $stable(out_positive))
        else $error("out_valid or result changed before out_ready");

    // Offered pixel holds until the input slice takes it
    a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else $error("in_valid or in_data changed before in_ready");

    // No result right out of reset
    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else $error("out_valid high in the first cycle after reset");

endmodule

bind nn_layer_top nn_layer_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_data      (in_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_goodness (out_goodness),
    .out_positive (out_positive)
);

/* test/nn_layer_tb.sv */
// Testbench for the streaming layer with goodness output
// Directed and random vectors checked against a reference model
`timescale 1ns/1ns
`include "nn_cfg.svh"

module nn_layer_tb
    import nn_fixed_pkg::*;
    import nn_layer_pkg::*;
();

    localparam int NUM_DIRECTED = 7;
    localparam int NUM_ROWS     = NUM_DIRECTED + 10;
    localparam int NUM_SETS     = 3;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (`NN_INPUT_SIZE + `NN_NUM_NEURONS + 20)
        + NUM_SETS * `NN_NUM_NEURONS * `NN_INPUT_SIZE + 40;

    // Directed rows use weight set 0 (identity) or 1 (negated identity)
    localparam int   DIR_WSET [NUM_DIRECTED] = '{0, 0, 0, 0, 0, 0, 1};
    localparam logic DIR_POS [NUM_DIRECTED]  = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
    // First four pixels, one per lane under identity weights
    localparam q16_t DIR_PIX [NUM_DIRECTED][4] = '{
        '{32'sh0002_0000, 32'sh0001_0000, 32'sh0000_8000, 32'sh0000_4000},
        '{32'sh0000_8000, 32'sh0000_8000, 32'sh0000_8000, 32'sh0000_8000},
        '{32'sh0001_0000, 32'sh0001_0000, 32'sh0000_ffff, 32'sh0000_0100},
        '{32'sh0001_0000, 32'sh0001_0000, 32'sh0001_0000, 32'sh0000_0000},
        '{32'sh0001_0000, 32'sh0001_0000, 32'sh0001_0000, 32'sh0000_0100},
        '{-32'sh0002_0000, 32'sh0001_0000, -32'sh0001_0000, 32'sh0001_8000},
        '{32'sh0001_0000, 32'sh0002_0000, 32'sh0003_0000, 32'sh0004_0000}
    };

    logic        clk;
    logic        rst_n;
    logic        wt_we;
    neuron_idx_t wt_neuron;
    pixel_idx_t  wt_index;
    q16_t        wt_data;
    logic        in_valid;
    logic        in_ready;
    q16_t        in_data;
    logic        out_valid;
    logic        out_ready;
    q16_t        out_goodness;
    logic        out_positive;

    q16_t        pix [NUM_ROWS][`NN_INPUT_SIZE];
    logic [31:0] lfsr;
    int          passed;
    int          failed;

    nn_layer_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wt_we        (wt_we),
        .wt_neuron    (wt_neuron),
        .wt_index     (wt_index),
        .wt_data      (wt_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_goodness (out_goodness),
        .out_positive (out_positive)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < count; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Set 2 is a dense mix of small positive and negative weights
    function automatic q16_t weight_val(input int set, input int n, input int i);
        case (set)
            0: return (i == n) ? 32'sh0001_0000 : '0;
            1: return (i == n) ? -32'sh0001_0000 : '0;
            default: return q16_t'(((n * 8 + i * 3) % 7 - 3) * 32'sh0000_4000);
        endcase
    endfunction

    function automatic int row_wset(input int row);
        if (row < NUM_DIRECTED) begin
            return DIR_WSET[row];
        end
        return 2;
    endfunction

    function automatic string row_name(input int row);
        case (row)
            0: return "positive";
            1: return "small";
            2: return "below_theta";
            3: return "at_theta";
            4: return "above_theta";
            5: return "relu_mixed";
            6: return "relu_all_neg";
            default: return "pipelined";
        endcase
    endfunction

    // Reference goodness: ReLU per lane, then sum of rescaled squares
    function automatic q16_t model_goodness(input int row);
        logic signed [63:0] lane_sum;
        logic signed [63:0] a;
        logic signed [63:0] b;
        logic signed [63:0] total;
        q16_t               act_v;
        total = '0;
        for (int n = 0; n < `NN_NUM_NEURONS; n++) begin
            lane_sum = '0;
            for (int i = 0; i < `NN_INPUT_SIZE; i++) begin
                a = pix[row][i];
                b = weight_val(row_wset(row), n, i);
                lane_sum = lane_sum + a * b;
            end
            lane_sum = lane_sum >>> `NN_FRAC_BITS;
            act_v = lane_sum[31:0];
            if (act_v < 0) begin
                act_v = '0;
            end
            a = act_v;
            total = total + ((a * a) >>> `NN_FRAC_BITS);
        end
        return total[31:0];
    endfunction

    // Directed pixels plus a filler that zero weights must ignore
    task automatic build_table();
        logic [31:0] v;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i < `NN_INPUT_SIZE; i++) begin
                if (r < NUM_DIRECTED) begin
                    pix[r][i] = (i < 4) ? DIR_PIX[r][i] : 32'sh0007_0000;
                end else begin
                    // Signed 18 bits, about +-2.0
                    v = rand_bits(18);
                    pix[r][i] = {{14{v[17]}}, v[17:0]};
                end
            end
        end
    endtask

    task automatic load_weights(input int set);
        for (int n = 0; n < `NN_NUM_NEURONS; n++) begin
            for (int i = 0; i < `NN_INPUT_SIZE; i++) begin
                @(posedge clk);
                wt_we     <= 1'b1;
                wt_neuron <= neuron_idx_t'(n);
                wt_index  <= pixel_idx_t'(i);
                wt_data   <= weight_val(set, n, i);
            end
        end
        @(posedge clk);
        wt_we <= 1'b0;
    endtask

    task automatic check_result(input int row);
        q16_t exp_g;
        logic exp_p;
        logic ok;
        exp_g = model_goodness(row);
        if (row < NUM_DIRECTED) begin
            exp_p = DIR_POS[row];
        end else begin
            exp_p = (exp_g > `NN_THETA);
        end
        ok = 1'b1;
        if (out_goodness !== exp_g) begin
            $display("FAILED row %0d out_goodness: got %h expected %h", row, out_goodness, exp_g);
            ok = 1'b0;
        end
        if (out_positive !== exp_p) begin
            $display("FAILED row %0d out_positive: got %h expected %h", row, out_positive, exp_p);
            ok = 1'b0;
        end
        if (ok) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d %s: goodness %h positive %b %s", row, row_name(row),
                 out_goodness, out_positive, ok ? "ok" : "wrong");
    endtask

    // Streams rows lo..hi-1 with random gaps and stalls, checks results in order
    task automatic run_batch(input int lo, input int hi);
        int send_row;
        int send_pix;
        int recv_row;
        send_row = lo;
        send_pix = 0;
        recv_row = lo;
        while (recv_row < hi) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                if (send_pix == `NN_INPUT_SIZE - 1) begin
                    send_pix = 0;
                    send_row++;
                end else begin
                    send_pix++;
                end
            end
            if (out_valid && out_ready) begin
                check_result(recv_row);
                recv_row++;
            end
            // Held pixel stays put until taken
            if (!(in_valid && !in_ready)) begin
                if (send_row < hi && rand_bits(2) != 0) begin
                    in_valid <= 1'b1;
                    in_data  <= pix[send_row][send_pix];
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= (rand_bits(1) != 0);
        end
        out_ready <= 1'b0;
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int lo;
        int hi;
        rst_n     = 1'b0;
        wt_we     = 1'b0;
        wt_neuron = '0;
        wt_index  = '0;
        wt_data   = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        passed    = 0;
        failed    = 0;
        lfsr      = 32'h8e46_2d3b;
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // Idle state right after reset
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("FAILED reset out_valid/in_ready: got %h/%h expected 0/1", out_valid,
                     in_ready);
            failed++;
        end else begin
            passed++;
        end
        $display("test reset: out_valid %b in_ready %b", out_valid, in_ready);
        // Rows sharing a weight set run as one batch
        lo = 0;
        while (lo < NUM_ROWS) begin
            hi = lo + 1;
            while (hi < NUM_ROWS && row_wset(hi) == row_wset(lo)) begin
                hi++;
            end
            load_weights(row_wset(lo));
            run_batch(lo, hi);
            lo = hi;
        end
        // Nothing left over once every vector has its result
        out_ready <= 1'b1;
        hi = 0;
        repeat (20) begin
            @(posedge clk);
            if (out_valid) begin
                hi++;
            end
        end
        if (hi != 0) begin
            $display("extra result seen after the last vector");
            failed++;
        end else begin
            passed++;
        end
        $display("test drain: %0d extra results", hi);
        $display("summary: %0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* nn_layer_top.f */
+incdir+include
verilog/nn_fixed_pkg.sv
verilog/nn_layer_pkg.sv
verilog/stream_reg.sv
verilog/pixel_feeder.sv
verilog/neuron_lane.sv
verilog/goodness_unit.sv
verilog/nn_layer_top.sv
test/nn_layer_chk.sv
test/nn_layer_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = nn_layer_tb
FILELIST = nn_layer_top.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
